// ==== Makefile ====
# Verilator flow for the memory stage.
TOP       ?= mem_stage_tb
FILELIST  ?= mem_stage.f
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
VERILATOR ?= verilator
VFLAGS    ?= --timing --assert -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o V$(TOP)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "RESULT: PASS" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== hw/mem_clint.sv ====
`timescale 1ns/10ps
module mem_clint (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              req_valid_i,
    input  mem_pkg::mem_req_t req_i,
    output logic              req_ready_o,
    output mem_pkg::mem_rsp_t rsp_o,
    output logic              timer_irq_o
);

    logic                     ready_q;
    logic                     accept;
    logic                     wr_cmp;
    logic [mem_pkg::xlen-1:0] mtime_q;
    logic [mem_pkg::xlen-1:0] mtimecmp_q;
    logic [mem_pkg::xlen-1:0] rdata_q;

    // a new request is taken in the cycle before ready.
    assign accept = req_valid_i & ~ready_q;
    assign wr_cmp = req_valid_i & ready_q & req_i.write
                  & (req_i.addr == mem_pkg::mtimecmp_addr);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ready_q <= 1'b0;
        end else begin
            ready_q <= accept;
        end
    end

    // free-running machine timer.
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mtime_q <= '0;
        end else begin
            mtime_q <= mtime_q + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mtimecmp_q <= '1;
        end else if (wr_cmp) begin
            for (int i = 0; i < mem_pkg::strb_w; i++) begin
                if (req_i.strb[i]) begin
                    mtimecmp_q[8*i +: 8] <= req_i.wdata[8*i +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            case (req_i.addr)
                mem_pkg::mtimecmp_addr: rdata_q <= mtimecmp_q;
                mem_pkg::mtime_addr:    rdata_q <= mtime_q;
                default:                rdata_q <= '0;
            endcase
        end
    end

    assign req_ready_o = ready_q;
    assign rsp_o.rdata = rdata_q;

    assign timer_irq_o = (mtime_q >= mtimecmp_q);

endmodule

// ==== hw/mem_dstb.sv ====
`timescale 1ns/10ps
module mem_dstb (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              in_valid_i,
    input  mem_pkg::mem_req_t in_req_i,
    output logic              in_ready_o,
    output mem_pkg::mem_rsp_t in_rsp_o,
    output logic              mem_valid_o,
    output mem_pkg::mem_req_t mem_req_o,
    input  logic              mem_ready_i,
    input  mem_pkg::mem_rsp_t mem_rsp_i,
    output logic              clint_valid_o,
    output mem_pkg::mem_req_t clint_req_o,
    input  logic              clint_ready_i,
    input  mem_pkg::mem_rsp_t clint_rsp_i
);

    logic hit_clint;
    logic route_q;
    logic route_clint;

    assign hit_clint = (in_req_i.addr & mem_pkg::clint_mask) == mem_pkg::clint_base;

    // remembers the last target while no request is pending.
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            route_q <= 1'b0;
        end else if (in_valid_i) begin
            route_q <= hit_clint;
        end
    end

    assign route_clint = in_valid_i ? hit_clint : route_q;

    assign mem_valid_o   = in_valid_i & ~hit_clint;
    assign mem_req_o     = in_req_i;
    assign clint_valid_o = in_valid_i & hit_clint;
    assign clint_req_o   = in_req_i;

    // only the selected target's ready and data reach the requester.
    assign in_ready_o = route_clint ? clint_ready_i : mem_ready_i;
    assign in_rsp_o   = route_clint ? clint_rsp_i : mem_rsp_i;

endmodule

// ==== hw/mem_forward.sv ====
`timescale 1ns/10ps
module mem_forward (
    input  logic [mem_pkg::reg_idx_w-1:0] rs2_idx_i,
    input  logic                          rs2_en_i,
    input  logic [mem_pkg::reg_idx_w-1:0] wb_rd_idx_i,
    input  logic                          wb_rd_en_i,
    output logic                          sel_wb_o
);

    logic idx_match;
    logic wb_nonzero;

    // x0 is hardwired to zero and never forwards.
    assign wb_nonzero = |wb_rd_idx_i;
    assign idx_match  = (rs2_idx_i == wb_rd_idx_i);

    // the writeback stage holds the youngest pending write to rs2.
    assign sel_wb_o = rs2_en_i & wb_rd_en_i & wb_nonzero & idx_match;

endmodule

// ==== hw/mem_lsu.sv ====
`timescale 1ns/10ps
module mem_lsu (
    input  logic                     clk,
    input  logic                     rst_n_i,
    input  mem_pkg::mem_ctrl_t       ctrl_i,
    input  logic [mem_pkg::xlen-1:0] addr_i,
    input  logic [mem_pkg::xlen-1:0] store_data_i,
    output logic                     access_ok_o,
    output logic [mem_pkg::xlen-1:0] load_data_o,
    output logic                     req_valid_o,
    output mem_pkg::mem_req_t        req_o,
    input  logic                     req_ready_i,
    input  mem_pkg::mem_rsp_t        rsp_i
);

    logic                         is_mem;
    logic [2:0]                   offset;
    logic [1:0]                   size;
    logic [mem_pkg::strb_w-1:0]   strb_base;
    mem_pkg::mem_req_t            req_d;
    logic                         busy_q;
    mem_pkg::mem_req_t            req_q;
    logic [2:0]                   off_q;
    mem_pkg::load_type_e          ltype_q;
    logic [mem_pkg::xlen-1:0]     shifted;

    assign is_mem = ctrl_i.inst_valid & (ctrl_i.mem_read | ctrl_i.mem_write);
    assign offset = addr_i[2:0];

    // access size in bytes as log2.
    always_comb begin
        if (ctrl_i.mem_write) begin
            case (ctrl_i.store_type)
                mem_pkg::sb: size = 2'd0;
                mem_pkg::sh: size = 2'd1;
                mem_pkg::sw: size = 2'd2;
                default:     size = 2'd3;
            endcase
        end else begin
            case (ctrl_i.load_type)
                mem_pkg::lb, mem_pkg::lbu: size = 2'd0;
                mem_pkg::lh, mem_pkg::lhu: size = 2'd1;
                mem_pkg::lw, mem_pkg::lwu: size = 2'd2;
                default:                   size = 2'd3;
            endcase
        end
    end

    always_comb begin
        case (size)
            2'd0:    strb_base = 8'h01;
            2'd1:    strb_base = 8'h03;
            2'd2:    strb_base = 8'h0f;
            default: strb_base = 8'hff;
        endcase
    end

    always_comb begin
        req_d.addr  = {addr_i[mem_pkg::xlen-1:3], 3'b000};
        req_d.wdata = ctrl_i.mem_write ? (store_data_i << {offset, 3'b000}) : '0;
        req_d.strb  = strb_base << offset;
        req_d.write = ctrl_i.mem_write;
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy_q <= 1'b0;
        end else if (!busy_q) begin
            busy_q <= is_mem;
        end else if (req_ready_i) begin
            busy_q <= 1'b0;
        end
    end

    // request payload, held stable until the handshake.
    always_ff @(posedge clk) begin
        if (!busy_q && is_mem) begin
            req_q   <= req_d;
            off_q   <= offset;
            ltype_q <= ctrl_i.load_type;
        end
    end

    assign req_valid_o = busy_q;
    assign req_o       = req_q;

    assign access_ok_o = is_mem ? (busy_q & req_ready_i) : ctrl_i.inst_valid;

    // move the addressed bytes down to bit 0, then extend.
    assign shifted = rsp_i.rdata >> {off_q, 3'b000};

    always_comb begin
        case (ltype_q)
            mem_pkg::lb:  load_data_o = {{(mem_pkg::xlen-8){shifted[7]}}, shifted[7:0]};
            mem_pkg::lh:  load_data_o = {{(mem_pkg::xlen-16){shifted[15]}}, shifted[15:0]};
            mem_pkg::lw:  load_data_o = {{(mem_pkg::xlen-32){shifted[31]}}, shifted[31:0]};
            mem_pkg::lbu: load_data_o = {{(mem_pkg::xlen-8){1'b0}}, shifted[7:0]};
            mem_pkg::lhu: load_data_o = {{(mem_pkg::xlen-16){1'b0}}, shifted[15:0]};
            mem_pkg::lwu: load_data_o = {{(mem_pkg::xlen-32){1'b0}}, shifted[31:0]};
            default:      load_data_o = shifted;
        endcase
    end

endmodule

// ==== hw/mem_pkg.sv ====
package mem_pkg;

    localparam int xlen      = 64;
    localparam int reg_idx_w = 5;
    localparam int strb_w    = 8;

    // clint decode window, 64 KiB at 0x0200_0000.
    localparam logic [xlen-1:0] clint_base = 64'h0000_0000_0200_0000;
    localparam logic [xlen-1:0] clint_mask = 64'hffff_ffff_ffff_0000;

    localparam logic [xlen-1:0] mtimecmp_addr = 64'h0000_0000_0200_4000;
    localparam logic [xlen-1:0] mtime_addr    = 64'h0000_0000_0200_bff8;

    typedef enum logic [2:0] {
        lb  = 3'd0,
        lh  = 3'd1,
        lw  = 3'd2,
        ld  = 3'd3,
        lbu = 3'd4,
        lhu = 3'd5,
        lwu = 3'd6
    } load_type_e;

    typedef enum logic [1:0] {
        sb = 2'd0,
        sh = 2'd1,
        sw = 2'd2,
        sd = 2'd3
    } store_type_e;

    // doubleword-aligned request, wdata already placed in its byte lanes.
    typedef struct packed {
        logic [xlen-1:0]   addr;
        logic [xlen-1:0]   wdata;
        logic [strb_w-1:0] strb;
        logic              write;
    } mem_req_t;

    typedef struct packed {
        logic [xlen-1:0] rdata;
    } mem_rsp_t;

    typedef struct packed {
        logic        inst_valid;
        logic        mem_read;
        logic        mem_write;
        load_type_e  load_type;
        store_type_e store_type;
    } mem_ctrl_t;

endpackage

// ==== hw/mem_stage_top.sv ====
`timescale 1ns/10ps
module mem_stage_top (
    input  logic                          clk,
    input  logic                          rst_n_i,
    input  mem_pkg::mem_ctrl_t            ctrl_i,
    input  logic [mem_pkg::reg_idx_w-1:0] rs2_idx_i,
    input  logic                          rs2_en_i,
    input  logic [mem_pkg::reg_idx_w-1:0] wb_rd_idx_i,
    input  logic                          wb_rd_en_i,
    input  logic [mem_pkg::xlen-1:0]      rs2_data_i,
    input  logic [mem_pkg::xlen-1:0]      wb_rd_data_i,
    input  logic [mem_pkg::xlen-1:0]      ex2mem_rd_data_i,
    output logic                          access_ok_o,
    output logic [mem_pkg::xlen-1:0]      rd_data_o,
    output logic                          mem_valid_o,
    output mem_pkg::mem_req_t             mem_req_o,
    input  logic                          mem_ready_i,
    input  mem_pkg::mem_rsp_t             mem_rsp_i,
    output logic                          mtip_o
);

    logic                     sel_wb;
    logic [mem_pkg::xlen-1:0] store_data;
    logic [mem_pkg::xlen-1:0] load_data;
    logic                     lsu_valid;
    mem_pkg::mem_req_t        lsu_req;
    logic                     lsu_ready;
    mem_pkg::mem_rsp_t        lsu_rsp;
    logic                     clint_valid;
    mem_pkg::mem_req_t        clint_req;
    logic                     clint_ready;
    mem_pkg::mem_rsp_t        clint_rsp;

    mem_forward u_forward (
        .rs2_idx_i   (rs2_idx_i),
        .rs2_en_i    (rs2_en_i),
        .wb_rd_idx_i (wb_rd_idx_i),
        .wb_rd_en_i  (wb_rd_en_i),
        .sel_wb_o    (sel_wb)
    );

    assign store_data = sel_wb ? wb_rd_data_i : rs2_data_i;

    // ex2mem_rd_data_i carries the effective address for loads and stores.
    mem_lsu u_lsu (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .ctrl_i       (ctrl_i),
        .addr_i       (ex2mem_rd_data_i),
        .store_data_i (store_data),
        .access_ok_o  (access_ok_o),
        .load_data_o  (load_data),
        .req_valid_o  (lsu_valid),
        .req_o        (lsu_req),
        .req_ready_i  (lsu_ready),
        .rsp_i        (lsu_rsp)
    );

    mem_dstb u_dstb (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .in_valid_i    (lsu_valid),
        .in_req_i      (lsu_req),
        .in_ready_o    (lsu_ready),
        .in_rsp_o      (lsu_rsp),
        .mem_valid_o   (mem_valid_o),
        .mem_req_o     (mem_req_o),
        .mem_ready_i   (mem_ready_i),
        .mem_rsp_i     (mem_rsp_i),
        .clint_valid_o (clint_valid),
        .clint_req_o   (clint_req),
        .clint_ready_i (clint_ready),
        .clint_rsp_i   (clint_rsp)
    );

    mem_clint u_clint (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .req_valid_i (clint_valid),
        .req_i       (clint_req),
        .req_ready_o (clint_ready),
        .rsp_o       (clint_rsp),
        .timer_irq_o (mtip_o)
    );

    assign rd_data_o = ctrl_i.mem_read ? load_data : ex2mem_rd_data_i;

endmodule

// ==== mem_stage.f ====
hw/mem_pkg.sv
hw/mem_forward.sv
hw/mem_lsu.sv
hw/mem_dstb.sv
hw/mem_clint.sv
hw/mem_stage_top.sv
verif/tb_clk_gen.sv
verif/mem_stage_mon.sv
verif/mem_stage_chk.sv
verif/mem_stage_tb.sv

// ==== verif/mem_stage_chk.sv ====
`timescale 1ns/10ps
module mem_stage_chk (
    input logic               clk,
    input logic               rst_n_i,
    input mem_pkg::mem_ctrl_t ctrl_i,
    input logic               access_ok_i,
    input logic               req_valid_i,
    input mem_pkg::mem_req_t  req_i,
    input logic               req_ready_i
);

    logic is_mem;
    int   fail_cnt = 0;

    assign is_mem = ctrl_i.inst_valid & (ctrl_i.mem_read | ctrl_i.mem_write);

    req_held: assert property (@(posedge clk) disable iff (!rst_n_i)
        req_valid_i && !req_ready_i |=> req_valid_i && $stable(req_i))
        else begin
            $error("request changed or dropped while ready was low");
            fail_cnt++;
        end

    valid_drops: assert property (@(posedge clk) disable iff (!rst_n_i)
        req_valid_i && req_ready_i |=> !req_valid_i)
        else begin
            $error("valid still high after the handshake");
            fail_cnt++;
        end

    quiet_in_reset: assert property (@(posedge clk)
        !rst_n_i |-> !req_valid_i && !access_ok_i)
        else begin
            $error("valid or access_ok seen during reset");
            fail_cnt++;
        end

    // the load or store stays at the inputs until its handshake completes it.
    ok_at_handshake: assert property (@(posedge clk) disable iff (!rst_n_i)
        req_valid_i && req_ready_i |-> is_mem && access_ok_i)
        else begin
            $error("handshake without access_ok for the held load or store");
            fail_cnt++;
        end

endmodule

bind mem_lsu mem_stage_chk u_chk (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .ctrl_i      (ctrl_i),
    .access_ok_i (access_ok_o),
    .req_valid_i (req_valid_o),
    .req_i       (req_o),
    .req_ready_i (req_ready_i)
);

// ==== verif/mem_stage_mon.sv ====
`timescale 1ns/10ps
module mem_stage_mon (
    input  logic                     clk,
    input  logic                     rst_n_i,
    input  mem_pkg::mem_ctrl_t       ctrl_i,
    input  logic [mem_pkg::xlen-1:0] ex2mem_i,
    input  logic                     access_ok_i,
    input  logic [mem_pkg::xlen-1:0] rd_data_i,
    input  logic                     mem_valid_i,
    input  mem_pkg::mem_req_t        mem_req_i,
    input  logic                     mem_ready_i,
    input  logic                     mtip_i,
    input  logic [mem_pkg::xlen-1:0] exp_data_i,
    input  logic                     exp_chk_i,
    output int                       err_cnt_o
);

    logic [63:0] img [logic [63:0]];
    logic [63:0] mt;
    logic [63:0] cmp;
    logic [63:0] last_mtime;
    logic        have_mtime;
    int          errors = 0;

    assign err_cnt_o = errors;

    function automatic logic [63:0] dword_fill(logic [63:0] a);
        return a ^ {a[31:0], a[63:32]} ^ 64'h5a5a_a5a5_0f0f_f0f0;
    endfunction

    function automatic logic in_clint(logic [63:0] a);
        return (a & mem_pkg::clint_mask) == mem_pkg::clint_base;
    endfunction

    function automatic logic [7:0] strb_for(mem_pkg::store_type_e st, logic [2:0] off);
        logic [7:0] base;
        case (st)
            mem_pkg::sb: base = 8'h01;
            mem_pkg::sh: base = 8'h03;
            mem_pkg::sw: base = 8'h0f;
            default:     base = 8'hff;
        endcase
        return base << off;
    endfunction

    function automatic logic [63:0] extend(logic [63:0] raw, logic [2:0] off,
                                           mem_pkg::load_type_e lt);
        logic [63:0] s;
        s = raw >> (8 * off);
        case (lt)
            mem_pkg::lb:  return {{56{s[7]}}, s[7:0]};
            mem_pkg::lh:  return {{48{s[15]}}, s[15:0]};
            mem_pkg::lw:  return {{32{s[31]}}, s[31:0]};
            mem_pkg::lbu: return {56'b0, s[7:0]};
            mem_pkg::lhu: return {48'b0, s[15:0]};
            mem_pkg::lwu: return {32'b0, s[31:0]};
            default:      return s;
        endcase
    endfunction

    // bytes of the strobe taken from the lane-shifted value.
    function automatic logic [63:0] merge(logic [63:0] old, logic [63:0] lanes, logic [7:0] st);
        logic [63:0] res;
        res = old;
        for (int i = 0; i < 8; i++) begin
            if (st[i]) begin
                res[8*i +: 8] = lanes[8*i +: 8];
            end
        end
        return res;
    endfunction

    task automatic report_mismatch(string name, logic [63:0] got, logic [63:0] exp);
        $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
        errors++;
    endtask

    task automatic report_failure(string what);
        $display("Error: %s at %0t", what, $time);
        errors++;
    endtask

    task automatic check_store();
        logic [2:0]  off;
        logic [7:0]  st;
        logic [63:0] lanes;
        logic [63:0] dw;
        off   = ex2mem_i[2:0];
        st    = strb_for(ctrl_i.store_type, off);
        lanes = exp_data_i << (8 * off);
        dw    = {ex2mem_i[63:3], 3'b000};
        if (mem_req_i.addr !== dw) report_mismatch("mem_req_o.addr", mem_req_i.addr, dw);
        if (mem_req_i.strb !== st) report_mismatch("mem_req_o.strb", mem_req_i.strb, st);
        if (merge(64'b0, mem_req_i.wdata, st) !== merge(64'b0, lanes, st)) begin
            report_mismatch("mem_req_o.wdata", mem_req_i.wdata, lanes);
        end
        img[dw] = merge(img.exists(dw) ? img[dw] : dword_fill(dw), lanes, st);
    endtask

    task automatic check_result();
        logic [63:0] dw;
        logic [63:0] raw;
        logic [63:0] exp;
        dw = {ex2mem_i[63:3], 3'b000};
        if (ctrl_i.mem_write && in_clint(dw)) begin
            if (dw == mem_pkg::mtimecmp_addr) begin
                cmp = merge(cmp, exp_data_i << (8 * ex2mem_i[2:0]),
                            strb_for(ctrl_i.store_type, ex2mem_i[2:0]));
            end
        end else if (ctrl_i.mem_read && dw == mem_pkg::mtime_addr) begin
            if (have_mtime && rd_data_i <= last_mtime) begin
                report_failure("mtime did not increase between two reads");
            end
            last_mtime = rd_data_i;
            have_mtime = 1'b1;
        end else if (ctrl_i.mem_read) begin
            if (in_clint(dw)) begin
                raw = (dw == mem_pkg::mtimecmp_addr) ? cmp : 64'b0;
            end else begin
                raw = img.exists(dw) ? img[dw] : dword_fill(dw);
            end
            exp = extend(raw, ex2mem_i[2:0], ctrl_i.load_type);
            if (rd_data_i !== exp) report_mismatch("rd_data_o", rd_data_i, exp);
        end else if (!ctrl_i.mem_write && exp_chk_i && rd_data_i !== exp_data_i) begin
            report_mismatch("rd_data_o", rd_data_i, exp_data_i);
        end
    endtask

    // mt mirrors the free-running timer and cmp the compare register.
    always @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            mt         = '0;
            cmp        = '1;
            have_mtime = 1'b0;
        end else begin
            if (mtip_i !== (mt >= cmp)) report_mismatch("mtip_o", mtip_i, mt >= cmp);
            if (mem_valid_i && in_clint(mem_req_i.addr)) begin
                report_failure("memory port request inside the CLINT window");
            end
            if (mem_valid_i && !(ctrl_i.inst_valid && (ctrl_i.mem_read || ctrl_i.mem_write))) begin
                report_failure("memory port request without a load or store");
            end
            if (mem_valid_i && mem_ready_i && mem_req_i.write !== ctrl_i.mem_write) begin
                report_mismatch("mem_req_o.write", mem_req_i.write, ctrl_i.mem_write);
            end
            if (mem_valid_i && mem_ready_i && ctrl_i.mem_write) check_store();
            if (ctrl_i.inst_valid && access_ok_i) check_result();
            mt = mt + 64'd1;
        end
    end

endmodule

// ==== verif/mem_stage_tb.sv ====
`timescale 1ns/10ps
module mem_stage_tb;

    typedef enum logic [1:0] {op_alu, op_load, op_store} op_e;

    typedef struct packed {
        op_e                   op;
        mem_pkg::load_type_e   ltype;
        mem_pkg::store_type_e  stype;
        logic [63:0]           addr;
        logic [63:0]           rs2_data;
        logic [4:0]            rs2_idx;
        logic                  rs2_en;
        logic [4:0]            wb_idx;
        logic                  wb_en;
        logic [63:0]           wb_data;
        logic [63:0]           exp;
        logic                  chk;
    } entry_t;

    logic               clk;
    logic               rst_n;
    mem_pkg::mem_ctrl_t ctrl;
    logic [4:0]         rs2_idx;
    logic               rs2_en;
    logic [4:0]         wb_idx;
    logic               wb_en;
    logic [63:0]        rs2_data;
    logic [63:0]        wb_data;
    logic [63:0]        ex2mem;
    logic               access_ok;
    logic [63:0]        rd_data;
    logic               mem_valid;
    mem_pkg::mem_req_t  mem_req;
    logic               mem_ready;
    mem_pkg::mem_rsp_t  mem_rsp;
    logic               mtip;
    logic [63:0]        exp_data;
    logic               exp_chk;
    int                 err_cnt;

    entry_t      stim_q[$];
    logic        table_built = 1'b0;
    logic [63:0] mem [logic [63:0]];
    logic [31:0] lcg_state = 32'ha219_8617;
    logic [1:0]  delay;
    logic        pending;

    tb_clk_gen u_clk (.clk_o(clk), .rst_n_o(rst_n));

    mem_stage_top dut (
        .clk(clk), .rst_n_i(rst_n), .ctrl_i(ctrl),
        .rs2_idx_i(rs2_idx), .rs2_en_i(rs2_en), .wb_rd_idx_i(wb_idx), .wb_rd_en_i(wb_en),
        .rs2_data_i(rs2_data), .wb_rd_data_i(wb_data), .ex2mem_rd_data_i(ex2mem),
        .access_ok_o(access_ok), .rd_data_o(rd_data),
        .mem_valid_o(mem_valid), .mem_req_o(mem_req), .mem_ready_i(mem_ready),
        .mem_rsp_i(mem_rsp), .mtip_o(mtip)
    );

    mem_stage_mon u_mon (
        .clk(clk), .rst_n_i(rst_n), .ctrl_i(ctrl), .ex2mem_i(ex2mem),
        .access_ok_i(access_ok), .rd_data_i(rd_data), .mem_valid_i(mem_valid),
        .mem_req_i(mem_req), .mem_ready_i(mem_ready), .mtip_i(mtip),
        .exp_data_i(exp_data), .exp_chk_i(exp_chk), .err_cnt_o(err_cnt)
    );

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic logic [63:0] dword_fill(logic [63:0] a);
        return a ^ {a[31:0], a[63:32]} ^ 64'h5a5a_a5a5_0f0f_f0f0;
    endfunction

    task automatic add_store(mem_pkg::store_type_e st, logic [63:0] a, logic [63:0] v);
        stim_q.push_back('{op_store, mem_pkg::ld, st, a, v, 5'd1, 1'b1, 5'd0, 1'b0,
                           64'b0, v, 1'b0});
    endtask

    task automatic add_load(mem_pkg::load_type_e lt, logic [63:0] a);
        stim_q.push_back('{op_load, lt, mem_pkg::sd, a, 64'b0, 5'd0, 1'b0, 5'd0, 1'b0,
                           64'b0, 64'b0, 1'b0});
    endtask

    task automatic add_alu(logic [63:0] v);
        stim_q.push_back('{op_alu, mem_pkg::ld, mem_pkg::sd, v, 64'b0, 5'd0, 1'b0, 5'd0, 1'b0,
                           64'b0, v, 1'b1});
    endtask

    task automatic add_fwd(logic [4:0] ri, logic [4:0] wi, logic we, logic [63:0] a,
                           logic [63:0] rd, logic [63:0] wd, logic [63:0] exp);
        stim_q.push_back('{op_store, mem_pkg::ld, mem_pkg::sd, a, rd, ri, 1'b1, wi, we,
                           wd, exp, 1'b0});
    endtask

    task automatic drive_entry(entry_t e);
        ctrl.inst_valid = 1'b1;
        ctrl.mem_read   = (e.op == op_load);
        ctrl.mem_write  = (e.op == op_store);
        ctrl.load_type  = e.ltype;
        ctrl.store_type = e.stype;
        ex2mem   = e.addr;
        rs2_data = e.rs2_data;
        rs2_idx  = e.rs2_idx;
        rs2_en   = e.rs2_en;
        wb_idx   = e.wb_idx;
        wb_en    = e.wb_en;
        wb_data  = e.wb_data;
        exp_data = e.exp;
        exp_chk  = e.chk;
    endtask

    task automatic drive_idle();
        ctrl     = '0;
        ex2mem   = '0;
        rs2_data = '0;
        rs2_idx  = '0;
        rs2_en   = 1'b0;
        wb_idx   = '0;
        wb_en    = 1'b0;
        wb_data  = '0;
        exp_data = '0;
        exp_chk  = 1'b0;
    endtask

    task automatic build_table();
        for (int i = 0; i < 8; i++) add_store(mem_pkg::sb, 64'h8000_0100 + i,
                                              64'hcafe_0000_0000_0080 + 64'h11 * i);
        for (int i = 0; i < 4; i++) add_store(mem_pkg::sh, 64'h8000_0108 + 2 * i,
                                              64'h1234_5678_9abc_8000 + 64'h1111 * i);
        for (int i = 0; i < 2; i++) add_store(mem_pkg::sw, 64'h8000_0110 + 4 * i,
                                              64'h0bad_f00d_8765_4321 + 64'h1111_1111 * i);
        add_store(mem_pkg::sd, 64'h8000_0118, 64'hf0e1_d2c3_b4a5_9687);
        for (int i = 0; i < 8; i++) begin
            add_load(mem_pkg::lb, 64'h8000_0100 + i);
            add_load(mem_pkg::lbu, 64'h8000_0100 + i);
        end
        for (int i = 0; i < 4; i++) begin
            add_load(mem_pkg::lh, 64'h8000_0108 + 2 * i);
            add_load(mem_pkg::lhu, 64'h8000_0108 + 2 * i);
        end
        for (int i = 0; i < 2; i++) begin
            add_load(mem_pkg::lw, 64'h8000_0110 + 4 * i);
            add_load(mem_pkg::lwu, 64'h8000_0110 + 4 * i);
        end
        add_load(mem_pkg::ld, 64'h8000_0118);
        add_load(mem_pkg::ld, 64'h8000_0100);
        // forwarding with a match, x0, another index and writeback disabled.
        add_fwd(5'd5, 5'd5, 1'b1, 64'h8000_0120, 64'h1111_1111_1111_1111,
                64'h2222_2222_2222_2222, 64'h2222_2222_2222_2222);
        add_fwd(5'd0, 5'd0, 1'b1, 64'h8000_0128, 64'h3333_3333_3333_3333,
                64'h4444_4444_4444_4444, 64'h3333_3333_3333_3333);
        add_fwd(5'd5, 5'd6, 1'b1, 64'h8000_0130, 64'h5555_5555_5555_5555,
                64'h6666_6666_6666_6666, 64'h5555_5555_5555_5555);
        add_fwd(5'd7, 5'd7, 1'b0, 64'h8000_0138, 64'h7777_7777_7777_7777,
                64'h8888_8888_8888_8888, 64'h7777_7777_7777_7777);
        for (int i = 0; i < 4; i++) add_load(mem_pkg::ld, 64'h8000_0120 + 8 * i);
        add_alu(64'h0123_4567_89ab_cdef);
        add_alu(64'hfedc_ba98_7654_3210);
        // clint timer.
        add_load(mem_pkg::ld, mem_pkg::mtime_addr);
        add_load(mem_pkg::ld, mem_pkg::mtime_addr);
        add_store(mem_pkg::sd, mem_pkg::mtimecmp_addr, 64'h0);
        add_alu(64'h0000_0000_0000_0042);
        add_store(mem_pkg::sd, mem_pkg::mtimecmp_addr, '1);
        add_alu(64'h0000_0000_0000_0043);
        add_load(mem_pkg::lw, mem_pkg::clint_base + 64'h10);
    endtask

    // external memory with a random ready delay of 0 to 3 cycles.
    always @(negedge clk or negedge rst_n) begin
        logic [31:0] r;
        if (!rst_n) begin
            mem_ready = 1'b0;
            pending   = 1'b0;
        end else if (mem_ready) begin
            mem_ready = 1'b0;
        end else if (mem_valid) begin
            if (!pending) begin
                r       = lcg_next();
                delay   = r[17:16];
                pending = 1'b1;
            end
            if (delay == 2'd0) begin
                mem_rsp.rdata = mem.exists(mem_req.addr) ? mem[mem_req.addr]
                                                         : dword_fill(mem_req.addr);
                if (mem_req.write) begin
                    for (int i = 0; i < 8; i++) begin
                        if (mem_req.strb[i]) mem_rsp.rdata[8*i +: 8] = mem_req.wdata[8*i +: 8];
                    end
                    mem[mem_req.addr] = mem_rsp.rdata;
                end
                mem_ready = 1'b1;
                pending   = 1'b0;
            end else begin
                delay = delay - 2'd1;
            end
        end
    end

    initial begin
        wait (table_built);
        #(stim_q.size() * 20 * 8);
        $display("Error: timeout, the stimulus table did not finish in time");
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        drive_idle();
        mem_ready = 1'b0;
        mem_rsp   = '0;
        build_table();
        table_built = 1'b1;
        wait (rst_n);
        foreach (stim_q[i]) begin
            @(negedge clk);
            drive_entry(stim_q[i]);
            @(posedge clk);
            while (!access_ok) @(posedge clk);
        end
        @(negedge clk);
        drive_idle();
        repeat (3) @(negedge clk);
        $display("checks done: %0d entries, %0d errors, %0d assertion failures",
                 stim_q.size(), err_cnt, dut.u_lsu.u_chk.fail_cnt);
        if (err_cnt == 0 && dut.u_lsu.u_chk.fail_cnt == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== verif/tb_clk_gen.sv ====
`timescale 1ns/10ps
module tb_clk_gen (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #4 clk_o = ~clk_o;
    end

    // reset released on a falling edge after 5 cycles.
    initial begin
        rst_n_o = 1'b0;
        repeat (5) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

endmodule
